/* erx_pkg.sv */
// elink receive definitions
package erx_pkg;

   // ####################
   // sizes
   // ####################
   localparam int pw         = 104; // mesh packet width
   localparam int sw         = 112; // raw sample, seven link words
   localparam int words      = 7;   // words in a full packet
   localparam int burst_ptr  = 3;   // slot reloaded while frame stays high
   localparam int stretch_dw = 3;   // stretch length, pulse comes out 4 wide

   // ####################
   // packet
   // ####################

   // mesh packet fields, msb first
   typedef struct packed
   {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
   } erx_packet_s;

   // same word, by field or as the flat bus
   typedef union packed
   {
      erx_packet_s   fld;
      logic [pw-1:0] flat;
   } erx_packet_u;

endpackage

/* pulse_stretcher.sv */
// pulse stretcher
module pulse_stretcher
#(
   parameter int dw = erx_pkg::stretch_dw
)
(
   input  logic clk,
   input  logic erx_io_reset,
   input  logic in,
   output logic out
);

   logic [dw:0] stages;  // dw+1 cycles of history

   always_ff @(posedge clk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
         stages <= '0;
      else
         stages <= {stages[dw-1:0], in};
   end

   assign out = |stages;  // high while the pulse is anywhere in the chain

endmodule

/* erx_ddr_sampler.sv */
// elink ddr input sampler
module erx_ddr_sampler
(
   input  logic                                  rx_lclk,
   input  logic                                  erx_io_reset,
   input  logic [7:0]                            rxi_data,
   input  logic                                  rxi_frame,
   output logic [erx_pkg::sw/erx_pkg::words-1:0] rx_word,   // {fall byte, rise byte}
   output logic                                  rx_frame
);
   import erx_pkg::*;

   logic [sw/words/2-1:0] rise_q;  // byte seen at rising edge
   logic [sw/words/2-1:0] fall_q;  // byte seen at falling edge
   logic                  frame_q;

   // rise byte, then both halves out together on the next rise
   always_ff @(posedge rx_lclk)
   begin
      rise_q  <= rxi_data;
      rx_word <= {fall_q, rise_q}; // rise byte low
   end

   always_ff @(negedge rx_lclk)
   begin
      fall_q <= rxi_data;          // second half of the word
   end

   // frame goes through the same two stages as the rise byte
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
      begin
         frame_q  <= 1'b0;
         rx_frame <= 1'b0;
      end
      else
      begin
         frame_q  <= rxi_frame;
         rx_frame <= frame_q;
      end
   end

endmodule

/* erx_frame_assembler.sv */
// elink frame assembler
module erx_frame_assembler
(
   input  logic                                  rx_lclk,
   input  logic                                  erx_io_reset,
   input  logic [erx_pkg::sw/erx_pkg::words-1:0] rx_word,
   input  logic                                  rx_frame,
   output logic [erx_pkg::sw-1:0]                rx_sample,
   output logic                                  access,        // last word is in
   output logic                                  valid_packet,  // access, one cycle later
   output logic                                  burst_detect
);
   import erx_pkg::*;

   logic [words-1:0] ptr;  // one-hot word slot

   // ####################
   // word pointer
   // ####################
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
         ptr <= '0;
      else if (!rx_frame)
         ptr <= words'(1);                 // idle, park on slot 0
      else if (ptr[words-1])
         ptr <= words'(1) << burst_ptr;    // frame still high, burst goes on
      else
         ptr <= ptr << 1;                  // middle of frame
   end

   // each pointed slot takes the word
   always_ff @(posedge rx_lclk)
   begin
      for (int i = 0; i < words; i++)
      begin
         if (rx_frame && ptr[i])
            rx_sample[i*(sw/words) +: sw/words] <= rx_word;
      end
   end

   // ####################
   // data valid
   // ####################

   // frame qualifier keeps a short frame from firing
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
      begin
         access       <= 1'b0;
         valid_packet <= 1'b0;
      end
      else
      begin
         access       <= ptr[words-1] & rx_frame;
         valid_packet <= access;           // data pipeline
      end
   end

   // high from the end of the first packet until the frame drops
   always_ff @(posedge rx_lclk or posedge erx_io_reset)
   begin
      if (erx_io_reset)
         burst_detect <= 1'b0;
      else if (access && rx_frame)
         burst_detect <= 1'b1;
      else if (!rx_frame)
         burst_detect <= 1'b0;
   end

endmodule

/* erx_packet_decode.sv */
// elink packet decode
module erx_packet_decode
(
   input  logic                   rx_lclk,
   input  logic                   access,
   input  logic                   burst_detect,
   input  logic [erx_pkg::sw-1:0] rx_sample,
   output erx_pkg::erx_packet_u   packet_lclk,
   output logic                   burst_lclk
);

   // ####################
   // field shuffle
   // ####################

   // held from the cycle after access
   always_ff @(posedge rx_lclk)
   begin
      if (access)
      begin
         burst_lclk <= burst_detect;       // lags a packet so the first one reads 0

         // flags sit in word 2
         packet_lclk.fld.access   <= rx_sample[40];
         packet_lclk.fld.write    <= rx_sample[41];
         packet_lclk.fld.datamode <= rx_sample[43:42];
         packet_lclk.fld.ctrlmode <= rx_sample[15:12];  // top nibble of word 0

         // dstaddr spans words 0 to 2 with bytes swapped
         packet_lclk.fld.dstaddr  <= {rx_sample[11:8],
                                      rx_sample[23:16],
                                      rx_sample[31:24],
                                      rx_sample[39:32],
                                      rx_sample[47:44]};

         packet_lclk.fld.data     <= {rx_sample[55:48],
                                      rx_sample[63:56],
                                      rx_sample[71:64],
                                      rx_sample[79:72]};

         packet_lclk.fld.srcaddr  <= {rx_sample[87:80],
                                      rx_sample[95:88],
                                      rx_sample[103:96],
                                      rx_sample[111:104]};
      end
   end

endmodule

/* erx_slow_capture.sv */
// quarter rate capture
module erx_slow_capture
(
   input  logic                   rx_lclk,
   input  logic                   rx_lclk_div4,
   input  logic                   erx_io_reset,
   input  logic                   valid_packet,
   input  logic [erx_pkg::pw-1:0] packet_lclk,
   input  logic                   burst_lclk,
   output logic                   rx_access,
   output logic                   rx_burst,
   output logic [erx_pkg::pw-1:0] rx_packet
);
   import erx_pkg::*;

   logic access_wide;  // valid_packet held 4 fast cycles

   // wide enough for one slow edge to see it
   pulse_stretcher #(.dw(stretch_dw)) u_stretch
   (
      .clk          (rx_lclk),
      .erx_io_reset (erx_io_reset),
      .in           (valid_packet),
      .out          (access_wide)
   );

   // ####################
   // slow clock side
   // ####################
   always_ff @(posedge rx_lclk_div4 or posedge erx_io_reset)
   begin
      if (erx_io_reset)
         rx_access <= 1'b0;
      else
         rx_access <= access_wide;
   end

   // fast side holds these steady while access_wide is up
   always_ff @(posedge rx_lclk_div4)
   begin
      if (access_wide)
      begin
         rx_packet <= packet_lclk;
         rx_burst  <= burst_lclk;
      end
   end

endmodule

/* erx_io.sv */
// elink receive io top
module erx_io
(
   input  logic                   erx_io_reset,
   input  logic                   rx_lclk,        // fast link clock
   input  logic                   rx_lclk_div4,   // quarter rate
   input  logic [7:0]             rxi_data,
   input  logic                   rxi_frame,
   output logic                   rx_access,
   output logic                   rx_burst,
   output logic [erx_pkg::pw-1:0] rx_packet
);
   import erx_pkg::*;

   logic [sw/words-1:0] rx_word;
   logic                rx_frame;
   logic [sw-1:0]       rx_sample;
   logic                access;
   logic                valid_packet;
   logic                burst_detect;
   erx_packet_u         packet_lclk;
   logic                burst_lclk;

   // ####################
   // fast clock chain
   // ####################
   erx_ddr_sampler u_sampler
   (
      .rx_lclk      (rx_lclk),
      .erx_io_reset (erx_io_reset),
      .rxi_data     (rxi_data),
      .rxi_frame    (rxi_frame),
      .rx_word      (rx_word),
      .rx_frame     (rx_frame)
   );

   erx_frame_assembler u_assembler
   (
      .rx_lclk      (rx_lclk),
      .erx_io_reset (erx_io_reset),
      .rx_word      (rx_word),
      .rx_frame     (rx_frame),
      .rx_sample    (rx_sample),
      .access       (access),
      .valid_packet (valid_packet),
      .burst_detect (burst_detect)
   );

   erx_packet_decode u_decode
   (
      .rx_lclk      (rx_lclk),
      .access       (access),
      .burst_detect (burst_detect),
      .rx_sample    (rx_sample),
      .packet_lclk  (packet_lclk),
      .burst_lclk   (burst_lclk)
   );

   // handoff to the slow domain, flat view of the packet
   erx_slow_capture u_capture
   (
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .erx_io_reset (erx_io_reset),
      .valid_packet (valid_packet),
      .packet_lclk  (packet_lclk.flat),
      .burst_lclk   (burst_lclk),
      .rx_access    (rx_access),
      .rx_burst     (rx_burst),
      .rx_packet    (rx_packet)
   );

endmodule

/* tb_erx_io.sv */
// elink receive testbench
module tb_erx_io;
   timeunit 1ns;
   timeprecision 100ps;
   import erx_pkg::*;

   localparam int period_ns    = 8;
   localparam int num_frames   = 24;  // fixed, random, burst, cut, recovery
   localparam int frame_cycles = 80;  // align, words, gap, wait, quiet check
   localparam int watchdog_ns  = 2 * period_ns * (5 + 40 + num_frames * frame_cycles);

   logic          rx_lclk = 1'b0;
   logic          erx_io_reset;
   logic [1:0]    div_cnt;
   logic          rx_lclk_div4;
   logic [7:0]    rxi_data;
   logic          rxi_frame;
   logic          rx_access;
   logic          rx_burst;
   logic [pw-1:0] rx_packet;

   logic [15:0]   word_q[$];     // words of the next frame
   logic [pw-1:0] got_pkt[$];    // packets seen on the slow side
   logic          got_burst[$];
   logic          access_seen;
   logic [pw-1:0] last_packet;
   logic [31:0]   lcg_state = 32'd98519;
   int            errors;
   int            checks;

   always #(period_ns/2) rx_lclk = ~rx_lclk;

   // quarter rate clock with its edges on the falling fast edge
   always @(negedge rx_lclk)
      div_cnt <= div_cnt + 2'd1;
   assign rx_lclk_div4 = div_cnt[1];

   erx_io u_erx_io
   (
      .erx_io_reset (erx_io_reset),
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .rxi_data     (rxi_data),
      .rxi_frame    (rxi_frame),
      .rx_access    (rx_access),
      .rx_burst     (rx_burst),
      .rx_packet    (rx_packet)
   );

   // ####################
   // stimulus helpers
   // ####################
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic erx_packet_u random_packet();
      erx_packet_u p;
      logic [31:0] r;
      p.fld.srcaddr  = lcg_next();
      p.fld.data     = lcg_next();
      p.fld.dstaddr  = lcg_next();
      r              = lcg_next();
      p.fld.ctrlmode = r[19:16];    // upper lcg bits
      p.fld.datamode = r[21:20];
      p.fld.write    = r[22];
      p.fld.access   = r[23];
      return p;
   endfunction

   // link sample that decodes to p with the low byte of word 0 unused
   function automatic logic [sw-1:0] build_sample(input erx_packet_u p);
      logic [sw-1:0] s;
      s        = '0;
      s[40]    = p.fld.access;
      s[41]    = p.fld.write;
      s[43:42] = p.fld.datamode;
      s[15:12] = p.fld.ctrlmode;
      {s[11:8], s[23:16], s[31:24], s[39:32], s[47:44]} = p.fld.dstaddr;
      {s[55:48], s[63:56], s[71:64], s[79:72]}          = p.fld.data;
      {s[87:80], s[95:88], s[103:96], s[111:104]}       = p.fld.srcaddr;
      return s;
   endfunction

   task automatic queue_words(input logic [sw-1:0] s, input int first, input int last);
      int k;
      for (k = first; k <= last; k++)
         word_q.push_back(s[k*16 +: 16]);
   endtask

   // low byte ahead of the rise and high byte ahead of the fall
   task automatic drive_frame();
      int          k;
      logic [15:0] w;
      @(posedge rx_lclk);
      while (div_cnt != 2'd1)      // fixed div4 phase so every burst packet meets a slow edge
         @(posedge rx_lclk);
      rxi_frame <= 1'b1;
      for (k = 0; k < word_q.size(); k++)
      begin
         if (k > 0)
         begin
            @(posedge rx_lclk);
            rxi_data <= w[15:8];
         end
         w = word_q[k];
         @(negedge rx_lclk);
         rxi_data <= w[7:0];
      end
      @(posedge rx_lclk);
      rxi_data  <= w[15:8];
      rxi_frame <= 1'b0;           // frame ends with the last word
      word_q.delete();
      repeat (4) @(posedge rx_lclk);
      rxi_data  <= 8'h00;
   endtask

   task automatic send_packet(input erx_packet_u p);
      queue_words(build_sample(p), 0, words-1);
      drive_frame();
   endtask

   // ####################
   // checkers
   // ####################
   task automatic expect_packet(input erx_packet_u exp, input logic exp_burst);
      int            n;
      logic [pw-1:0] got;
      logic          got_b;
      n = 0;
      while (got_pkt.size() == 0 && n < 120)
      begin
         @(posedge rx_lclk);
         n++;
      end
      checks++;
      if (got_pkt.size() == 0)
      begin
         errors++;
         $display("Error at %0d ns: no packet came out with rx_access", $time);
      end
      else
      begin
         got   = got_pkt.pop_front();
         got_b = got_burst.pop_front();
         if (got !== exp.flat)
         begin
            errors++;
            $display("Fail at %0d ns: rx_packet expected %h got %h", $time, exp.flat, got);
         end
         if (got_b !== exp_burst)
         begin
            errors++;
            $display("Fail at %0d ns: rx_burst expected %b got %b", $time, exp_burst, got_b);
         end
      end
   endtask

   task automatic expect_quiet(input int slow_cycles);
      repeat (slow_cycles) @(posedge rx_lclk_div4);
      checks++;
      if (got_pkt.size() != 0)
      begin
         errors++;
         $display("Error at %0d ns: %0d packet(s) arrived that no frame should have made",
                  $time, got_pkt.size());
         got_pkt.delete();
         got_burst.delete();
      end
   endtask

   // ####################
   // directed tests
   // ####################
   task automatic check_idle_after_reset();
      repeat (10)
      begin
         @(negedge rx_lclk_div4);
         checks++;
         if (rx_access !== 1'b0)
         begin
            errors++;
            $display("Fail at %0d ns: rx_access expected 0 got %b", $time, rx_access);
         end
      end
      expect_quiet(1);
   endtask

   task automatic check_single_frame();
      erx_packet_u p;
      p.fld.srcaddr  = 32'h8000_0104;
      p.fld.data     = 32'hdead_beef;
      p.fld.dstaddr  = 32'h8080_1234;
      p.fld.ctrlmode = 4'h5;
      p.fld.datamode = 2'b10;
      p.fld.write    = 1'b1;
      p.fld.access   = 1'b1;
      send_packet(p);
      expect_packet(p, 1'b0);
      expect_quiet(4);
   endtask

   task automatic check_random_frames();
      erx_packet_u p;
      repeat (20)
      begin
         p = random_packet();
         send_packet(p);
         expect_packet(p, 1'b0);
      end
      expect_quiet(4);
   endtask

   // words 0 to 2 stay put so burst packets keep header and flags
   task automatic check_burst_frame();
      erx_packet_u first;
      erx_packet_u second;
      erx_packet_u third;
      erx_packet_u fresh;
      first  = random_packet();
      second = first;
      fresh  = random_packet();
      second.fld.data    = fresh.fld.data;
      second.fld.srcaddr = fresh.fld.srcaddr;
      third  = first;
      fresh  = random_packet();
      third.fld.data     = fresh.fld.data;
      third.fld.srcaddr  = fresh.fld.srcaddr;
      queue_words(build_sample(first), 0, words-1);
      queue_words(build_sample(second), burst_ptr, words-1);  // 4 more words
      queue_words(build_sample(third), burst_ptr, words-1);
      drive_frame();
      expect_packet(first, 1'b0);
      expect_packet(second, 1'b1);
      expect_packet(third, 1'b1);
      expect_quiet(8);
   endtask

   task automatic check_cut_frame();
      erx_packet_u p;
      p = random_packet();
      queue_words(build_sample(p), 0, words-2);   // frame drops before word 6
      drive_frame();
      expect_quiet(12);
      p = random_packet();
      send_packet(p);
      expect_packet(p, 1'b0);
      expect_quiet(4);
   endtask

   // distinct packets while rx_access is up, sampled in the middle of the slow cycle
   always @(negedge rx_lclk_div4)
   begin
      if (rx_access && (!access_seen || rx_packet != last_packet))
      begin
         got_pkt.push_back(rx_packet);
         got_burst.push_back(rx_burst);
      end
      access_seen = rx_access;
      last_packet = rx_packet;
   end

   initial
   begin
      errors       = 0;
      checks       = 0;
      access_seen  = 1'b0;
      last_packet  = '0;
      div_cnt      = 2'd0;
      erx_io_reset = 1'b1;
      rxi_data     = 8'h00;
      rxi_frame    = 1'b0;
      repeat (5) @(posedge rx_lclk);
      erx_io_reset <= 1'b0;
      check_idle_after_reset();
      check_single_frame();
      check_random_frames();
      check_burst_frame();
      check_cut_frame();
      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   // watchdog
   initial
   begin
      #(watchdog_ns);
      $display("Error: watchdog ran out after %0d ns, a test is stuck", watchdog_ns);
      $display("checks run %0d, errors %0d", checks, errors + 1);
      $display("Finished with errors");
      $finish;
   end

endmodule

/* tb.f */
erx_pkg.sv
pulse_stretcher.sv
erx_ddr_sampler.sv
erx_frame_assembler.sv
erx_packet_decode.sv
erx_slow_capture.sv
erx_io.sv
tb_erx_io.sv

/* run.sh */
#!/bin/sh
# compile and run the erx_io testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_erx_io -o sim_erx_io

out=$(./obj_dir/sim_erx_io)
echo "$out"

if echo "$out" | grep -q "^Finished with no errors$"; then
   exit 0
fi
exit 1
